//--- rtl/pf_pkg.sv
`default_nettype none

package pf_pkg;

    // Packet memory word address width
    localparam int ADDR_W = 8;
    // Packet word width
    localparam int DATA_W = 64;
    // Valid bytes of one word, 1 to 8
    localparam int INC_W = 4;
    // Per-packet byte counter
    localparam int CNT_W = 12;
    // Header match key, taken from the top of word 0
    localparam int KEY_W = 16;

    // Filter core FSM
    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_RECV,
        CORE_DECIDE,
        CORE_REPORT
    } core_state_e;

    // Per-packet decision
    typedef enum logic {
        PF_DROP,
        PF_ACCEPT
    } verdict_e;

    // Verdict word reported by each core
    typedef struct packed {
        verdict_e          verdict;
        logic [CNT_W-1:0]  byte_cnt;
    } verdict_t;

endpackage

`default_nettype wire

//--- rtl/snoop_if.sv
`timescale 1ns/10ps
`default_nettype none

interface snoop_if;

    // Broadcast payload, same on every core
    logic [pf_pkg::ADDR_W-1:0] addr;
    logic [pf_pkg::DATA_W-1:0] wr_data;
    logic [pf_pkg::INC_W-1:0]  byte_inc;

    // Hot strobes, only the selected core sees these
    logic                      wr_en;
    logic                      done;

    // Arbiter side drives everything
    modport arb (
        output addr, wr_data, byte_inc, wr_en, done
    );

    // Core side only listens
    modport core (
        input addr, wr_data, byte_inc, wr_en, done
    );

endinterface

`default_nettype wire

//--- rtl/tag_tree.sv
`timescale 1ns/10ps
`default_nettype none

module tag_tree #(
    parameter int N_CORES = 4,
    parameter int TAG_W   = 2
) (
    input  wire [N_CORES-1:0] rdy_in_i,
    input  wire               ack_i,
    output wire               rdy_o,
    output wire [TAG_W-1:0]   tag_o,
    output wire [N_CORES-1:0] ack_out_o
);

    // Tree is padded out to a full power of two
    localparam int LEAVES = 1 << TAG_W;

    // Heap layout: node k has children 2k+1 and 2k+2, root is node 0
    wire [2*LEAVES-2:0] node_rdy;
    wire [TAG_W-1:0]    node_tag [2*LEAVES-1];

    genvar i, lvl, j;

    // Leaves, padding leaves are never ready
    for (i = 0; i < LEAVES; i++) begin : g_leaf
        if (i < N_CORES) begin : g_real
            assign node_rdy[LEAVES-1+i] = rdy_in_i[i];
        end else begin : g_pad
            assign node_rdy[LEAVES-1+i] = 1'b0;
        end
        assign node_tag[LEAVES-1+i] = TAG_W'(i);
    end

    // One level of pairwise merges per tag bit
    for (lvl = 0; lvl < TAG_W; lvl++) begin : g_level
        for (j = 0; j < (1 << lvl); j++) begin : g_node
            localparam int K = (1 << lvl) - 1 + j;
            // Ready if either half has a free core
            assign node_rdy[K] = node_rdy[2*K+1] | node_rdy[2*K+2];
            // Left side wins, so the lowest index bubbles up
            assign node_tag[K] = node_rdy[2*K+1] ? node_tag[2*K+1] : node_tag[2*K+2];
        end
    end

    assign rdy_o = node_rdy[0];
    assign tag_o = node_tag[0];

    // Only the winning core gets the acknowledge
    for (i = 0; i < N_CORES; i++) begin : g_ack
        assign ack_out_o[i] = ack_i && rdy_o && (tag_o == TAG_W'(i));
    end

    // Never more than one core claimed, and never a busy one
    always_comb begin
        assert ($onehot0(ack_out_o) && ((ack_out_o & ~rdy_in_i) == '0))
            else $error("tag_tree: acknowledge not one-hot or sent to a busy core");
    end

endmodule

`default_nettype wire

//--- rtl/snoop_arb.sv
`timescale 1ns/10ps
`default_nettype none

module snoop_arb #(
    parameter int N_CORES = 4,
    parameter int TAG_W   = 2,
    parameter bit PESS    = 1'b0
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    // Upstream snooper
    input  wire                      ack_i,
    input  wire [pf_pkg::ADDR_W-1:0] addr_i,
    input  wire [pf_pkg::DATA_W-1:0] wr_data_i,
    input  wire [pf_pkg::INC_W-1:0]  byte_inc_i,
    input  wire                      wr_en_i,
    input  wire                      done_i,
    output wire                      rdy_o,
    // Filter cores
    input  wire [N_CORES-1:0]        core_rdy_i,
    output wire [N_CORES-1:0]        core_ack_o,
    snoop_if.arb                     sn [N_CORES]
);

    wire [TAG_W-1:0]   tag;
    logic [TAG_W-1:0]  tag_q;
    logic              hs_q;
    logic [TAG_W-1:0]  sel;
    logic [TAG_W-1:0]  sel_q;
    logic [N_CORES-1:0] wr_gate;
    logic [N_CORES-1:0] done_gate;

    // Steered signals after the optional delay
    logic [pf_pkg::ADDR_W-1:0] addr_s;
    logic [pf_pkg::DATA_W-1:0] data_s;
    logic [pf_pkg::INC_W-1:0]  inc_s;
    logic [N_CORES-1:0]        wr_s;
    logic [N_CORES-1:0]        done_s;

    // Tag tree sends the acknowledges straight to the cores
    tag_tree #(
        .N_CORES (N_CORES),
        .TAG_W   (TAG_W)
    ) u_tag_tree (
        .rdy_in_i  (core_rdy_i),
        .ack_i     (ack_i),
        .rdy_o     (rdy_o),
        .tag_o     (tag),
        .ack_out_o (core_ack_o)
    );

    // Remember the handshake and its winner for one cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hs_q  <= 1'b0;
            tag_q <= '0;
            sel_q <= '0;
        end else begin
            hs_q  <= rdy_o && ack_i;
            tag_q <= tag;
            sel_q <= sel;
        end
    end

    // New winner takes over the cycle after the handshake, then holds
    assign sel = hs_q ? tag_q : sel_q;

    // Gate the hot strobes to the selected core
    for (genvar i = 0; i < N_CORES; i++) begin : g_gate
        assign wr_gate[i]   = wr_en_i && (sel == TAG_W'(i));
        assign done_gate[i] = done_i  && (sel == TAG_W'(i));
    end

    if (PESS) begin : g_pess
        // Extra register stage on everything steered
        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_s   <= '0;
                done_s <= '0;
            end else begin
                wr_s   <= wr_gate;
                done_s <= done_gate;
            end
        end
        always_ff @(posedge clk) begin
            addr_s <= addr_i;
            data_s <= wr_data_i;
            inc_s  <= byte_inc_i;
        end
    end else begin : g_direct
        assign addr_s = addr_i;
        assign data_s = wr_data_i;
        assign inc_s  = byte_inc_i;
        assign wr_s   = wr_gate;
        assign done_s = done_gate;
    end

    // Payload goes to every core and strobes to one
    for (genvar i = 0; i < N_CORES; i++) begin : g_sn
        assign sn[i].addr     = addr_s;
        assign sn[i].wr_data  = data_s;
        assign sn[i].byte_inc = inc_s;
        assign sn[i].wr_en    = wr_s[i];
        assign sn[i].done     = done_s[i];
    end

    // Source must hold off while no core is free
    a_ack_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |-> rdy_o);

    // Words land in one core at most and only in a claimed one
    a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(wr_s) && ((wr_s & core_rdy_i) == '0));

endmodule

`default_nettype wire

//--- rtl/filter_core.sv
`timescale 1ns/10ps
`default_nettype none

module filter_core #(
    parameter logic [pf_pkg::KEY_W-1:0] MATCH_KEY = 16'h0800
) (
    input  wire               clk,
    input  wire               rst_n_i,
    snoop_if.core             sn,
    input  wire               ack_i,
    output wire               rdy_o,
    output wire               verdict_valid_o,
    output pf_pkg::verdict_t  verdict_o
);

    pf_pkg::core_state_e state_q;
    pf_pkg::core_state_e state_d;

    logic [pf_pkg::KEY_W-1:0] key_q;
    logic [pf_pkg::CNT_W-1:0] cnt_q;
    pf_pkg::verdict_e         verdict_q;

    // Next-state logic
    always_comb begin
        state_d = state_q;
        case (state_q)
            pf_pkg::CORE_IDLE: begin
                // Claimed by the arbiter
                if (ack_i) begin
                    state_d = pf_pkg::CORE_RECV;
                end
            end
            pf_pkg::CORE_RECV: begin
                // Last word already seen, done closes the packet
                if (sn.done) begin
                    state_d = pf_pkg::CORE_DECIDE;
                end
            end
            pf_pkg::CORE_DECIDE: begin
                state_d = pf_pkg::CORE_REPORT;
            end
            pf_pkg::CORE_REPORT: begin
                // Verdict shown for one cycle only
                state_d = pf_pkg::CORE_IDLE;
            end
            default: begin
                state_d = pf_pkg::CORE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= pf_pkg::CORE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Header key from word 0
    always_ff @(posedge clk) begin
        if (state_q == pf_pkg::CORE_RECV && sn.wr_en && sn.addr == '0) begin
            key_q <= sn.wr_data[pf_pkg::DATA_W-1 -: pf_pkg::KEY_W];
        end
    end

    // Byte count, restarts with each new packet
    always_ff @(posedge clk) begin
        if (state_q == pf_pkg::CORE_IDLE && ack_i) begin
            cnt_q <= '0;
        end else if (state_q == pf_pkg::CORE_RECV && sn.wr_en) begin
            cnt_q <= cnt_q + pf_pkg::CNT_W'(sn.byte_inc);
        end
    end

    // Compare once the whole packet is in
    always_ff @(posedge clk) begin
        if (state_q == pf_pkg::CORE_DECIDE) begin
            if (key_q == MATCH_KEY) begin
                verdict_q <= pf_pkg::PF_ACCEPT;
            end else begin
                verdict_q <= pf_pkg::PF_DROP;
            end
        end
    end

    // Free only when idle
    assign rdy_o = (state_q == pf_pkg::CORE_IDLE);

    assign verdict_valid_o    = (state_q == pf_pkg::CORE_REPORT);
    assign verdict_o.verdict  = verdict_q;
    assign verdict_o.byte_cnt = cnt_q;

    // Steering must not leak strobes to a core that was never claimed
    a_no_strobe_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        (sn.wr_en || sn.done) |-> (state_q != pf_pkg::CORE_IDLE));

    // Arbiter only acknowledges cores that advertised ready
    a_ack_only_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |-> (state_q == pf_pkg::CORE_IDLE));

endmodule

`default_nettype wire

//--- rtl/packet_filter_top.sv
`timescale 1ns/10ps
`default_nettype none

module packet_filter_top #(
    parameter int                       N_CORES   = 4,
    parameter int                       TAG_W     = 2,
    parameter bit                       PESS      = 1'b0,
    parameter logic [pf_pkg::KEY_W-1:0] MATCH_KEY = 16'h0800
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    // Upstream snooper handshake
    input  wire                      ack_i,
    output wire                      rdy_o,
    // Packet words and end of packet
    input  wire [pf_pkg::ADDR_W-1:0] addr_i,
    input  wire [pf_pkg::DATA_W-1:0] wr_data_i,
    input  wire [pf_pkg::INC_W-1:0]  byte_inc_i,
    input  wire                      wr_en_i,
    input  wire                      done_i,
    // One verdict port per core
    output wire [N_CORES-1:0]        verdict_valid_o,
    output pf_pkg::verdict_t [N_CORES-1:0] verdict_o
);

    // Per-core ready and acknowledge
    wire [N_CORES-1:0] core_rdy;
    wire [N_CORES-1:0] core_ack;

    // Steered snoop bundle for each core
    snoop_if sn_if [N_CORES] ();

    // Picks a free core and steers the packet to it
    snoop_arb #(
        .N_CORES (N_CORES),
        .TAG_W   (TAG_W),
        .PESS    (PESS)
    ) u_snoop_arb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ack_i      (ack_i),
        .addr_i     (addr_i),
        .wr_data_i  (wr_data_i),
        .byte_inc_i (byte_inc_i),
        .wr_en_i    (wr_en_i),
        .done_i     (done_i),
        .rdy_o      (rdy_o),
        .core_rdy_i (core_rdy),
        .core_ack_o (core_ack),
        .sn         (sn_if)
    );

    // Parallel filter cores
    for (genvar i = 0; i < N_CORES; i++) begin : g_core
        filter_core #(
            .MATCH_KEY (MATCH_KEY)
        ) u_filter_core (
            .clk             (clk),
            .rst_n_i         (rst_n_i),
            .sn              (sn_if[i]),
            .ack_i           (core_ack[i]),
            .rdy_o           (core_rdy[i]),
            .verdict_valid_o (verdict_valid_o[i]),
            .verdict_o       (verdict_o[i])
        );
    end

endmodule

`default_nettype wire

//--- testbench/tb_packet_filter.sv
`timescale 1ns/10ps
`default_nettype none

module tb_packet_filter;

    localparam int N_CORES = 4;
    localparam int TAG_W = 2;
    localparam bit PESS = 1'b0;
    localparam logic [pf_pkg::KEY_W-1:0] MATCH_KEY = 16'h0800;
    // Cycles from the done strobe to the verdict
    localparam int DONE_TO_VERDICT = PESS ? 3 : 2;
    // 3 single, 4 back to back, 3 around rdy checks, 4 directed, 60 random
    localparam int N_PKTS = 74;
    localparam int LIMIT = 40 * N_PKTS + 200;

    logic clk = 1'b0;
    logic rst_n_i;
    logic ack_i;
    logic [pf_pkg::ADDR_W-1:0] addr_i;
    logic [pf_pkg::DATA_W-1:0] wr_data_i;
    logic [pf_pkg::INC_W-1:0] byte_inc_i;
    logic wr_en_i;
    logic done_i;
    wire rdy_o;
    wire [N_CORES-1:0] verdict_valid_o;
    pf_pkg::verdict_t [N_CORES-1:0] verdict_o;

    integer seed = 32'hde5c;
    int cyc = 0;
    int cyc_seen = 0;
    logic rdy_seen;
    int pass_cnt = 0;
    int fail_cnt = 0;

    // Core occupancy model
    logic [N_CORES-1:0] busy = '0;

    // Outstanding packets, oldest first
    string name_q [$];
    pf_pkg::verdict_t exp_v_q [$];
    logic [TAG_W-1:0] exp_core_q [$];
    int due_q [$];

    packet_filter_top #(
        .N_CORES   (N_CORES),
        .TAG_W     (TAG_W),
        .PESS      (PESS),
        .MATCH_KEY (MATCH_KEY)
    ) dut_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ack_i           (ack_i),
        .rdy_o           (rdy_o),
        .addr_i          (addr_i),
        .wr_data_i       (wr_data_i),
        .byte_inc_i      (byte_inc_i),
        .wr_en_i         (wr_en_i),
        .done_i          (done_i),
        .verdict_valid_o (verdict_valid_o),
        .verdict_o       (verdict_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Hard stop if the DUT stalls
    always @(posedge clk) begin
        if (cyc >= LIMIT) begin
            $display("Error: run stopped at cycle %0d with %0d verdicts outstanding",
                     cyc, due_q.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Expected verdict from the header and the per-word byte counts
    function automatic pf_pkg::verdict_t expected_verdict(
        input logic [pf_pkg::DATA_W-1:0] hdr,
        input logic [pf_pkg::INC_W-1:0] incs [6],
        input int n
    );
        pf_pkg::verdict_t v;
        logic [pf_pkg::CNT_W-1:0] sum;
        int k;
        sum = '0;
        for (k = 0; k < n; k++) begin
            sum = sum + pf_pkg::CNT_W'(incs[k]);
        end
        if (hdr[pf_pkg::DATA_W-1 -: pf_pkg::KEY_W] == MATCH_KEY) begin
            v.verdict = pf_pkg::PF_ACCEPT;
        end else begin
            v.verdict = pf_pkg::PF_DROP;
        end
        v.byte_cnt = sum;
        return v;
    endfunction

    // Lowest index not held by a packet
    function automatic logic [TAG_W-1:0] lowest_free();
        logic [TAG_W-1:0] f;
        int k;
        f = '0;
        for (k = N_CORES - 1; k >= 0; k--) begin
            if (!busy[k]) begin
                f = TAG_W'(k);
            end
        end
        return f;
    endfunction

    function automatic string verdict_str(input pf_pkg::verdict_e v);
        return (v == pf_pkg::PF_ACCEPT) ? "ACCEPT" : "DROP";
    endfunction

    task automatic compare_verdict(input string name, input pf_pkg::verdict_t exp,
                                   input pf_pkg::verdict_t act, output bit ok);
        ok = (exp === act);
        if (!ok) begin
            $display("Mismatch %s: expected %s/%0d bytes, actual %s/%0d bytes", name,
                     verdict_str(exp.verdict), exp.byte_cnt,
                     verdict_str(act.verdict), act.byte_cnt);
        end
    endtask

    task automatic compare_tag(input string name, input logic [TAG_W-1:0] exp,
                               input logic [TAG_W-1:0] act, output bit ok);
        ok = (exp === act);
        if (!ok) begin
            $display("Mismatch %s: expected core %0d, actual core %0d", name, exp, act);
        end
    endtask

    task automatic compare_rdy(input string name, input logic exp, input logic act,
                               output bit ok);
        ok = (exp === act);
        if (!ok) begin
            $display("Mismatch %s: expected rdy_o %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s", name);
        end
    endtask

    // Verdict monitor, runs on the falling edge where outputs are settled
    task automatic check_verdicts();
        int hits;
        int c;
        int k;
        bit ok_t;
        bit ok_v;
        bit ok_c;
        hits = 0;
        c = 0;
        for (k = 0; k < N_CORES; k++) begin
            if (verdict_valid_o[k]) begin
                hits++;
                c = k;
            end
        end
        if (hits > 1) begin
            $display("Error: %0d cores reported a verdict in the same cycle", hits);
            fail_cnt++;
        end
        if (hits != 0) begin
            if (due_q.size() == 0) begin
                $display("Error: verdict on core %0d with no packet outstanding", c);
                fail_cnt++;
            end else begin
                ok_c = (cyc == due_q[0]);
                if (!ok_c) begin
                    $display("Error: %s verdict came at cycle %0d instead of cycle %0d",
                             name_q[0], cyc, due_q[0]);
                end
                compare_tag(name_q[0], exp_core_q[0], TAG_W'(c), ok_t);
                compare_verdict(name_q[0], exp_v_q[0], verdict_o[c], ok_v);
                report_test(name_q[0], ok_c && ok_t && ok_v);
                void'(name_q.pop_front());
                void'(exp_v_q.pop_front());
                void'(exp_core_q.pop_front());
                void'(due_q.pop_front());
            end
            busy[c] = 1'b0;
        end else if (due_q.size() != 0 && cyc > due_q[0]) begin
            $display("Error: %s verdict never arrived", name_q[0]);
            report_test(name_q[0], 1'b0);
            void'(name_q.pop_front());
            void'(exp_v_q.pop_front());
            void'(exp_core_q.pop_front());
            void'(due_q.pop_front());
        end
    endtask

    // One clock: sample and check at the falling edge, return on the rising edge
    task automatic step();
        @(negedge clk);
        rdy_seen = rdy_o;
        cyc_seen = cyc;
        check_verdicts();
        @(posedge clk);
    endtask

    task automatic send_packet(input string name, input int nw,
                               input logic [pf_pkg::KEY_W-1:0] key);
        logic [pf_pkg::DATA_W-1:0] hdr;
        logic [pf_pkg::DATA_W-1:0] word;
        logic [pf_pkg::INC_W-1:0] incs [6];
        logic [31:0] r;
        logic [TAG_W-1:0] core;
        int w;
        hdr = '0;
        for (w = 0; w < 6; w++) begin
            incs[w] = '0;
        end
        // Source waits while no core is free
        step();
        while (!rdy_seen) begin
            step();
        end
        core = lowest_free();
        busy[core] = 1'b1;
        ack_i <= 1'b1;
        for (w = 0; w < nw; w++) begin
            step();
            word = {$random(seed), $random(seed)};
            if (w == 0) begin
                word[pf_pkg::DATA_W-1 -: pf_pkg::KEY_W] = key;
                hdr = word;
            end
            r = $random(seed);
            incs[w] = pf_pkg::INC_W'(r % 8 + 1);
            ack_i <= 1'b0;
            wr_en_i <= 1'b1;
            addr_i <= pf_pkg::ADDR_W'(w);
            wr_data_i <= word;
            byte_inc_i <= incs[w];
        end
        step();
        ack_i <= 1'b0;
        wr_en_i <= 1'b0;
        done_i <= 1'b1;
        name_q.push_back(name);
        exp_v_q.push_back(expected_verdict(hdr, incs, nw));
        exp_core_q.push_back(core);
        due_q.push_back(cyc_seen + 1 + DONE_TO_VERDICT);
        step();
        done_i <= 1'b0;
    endtask

    // Random length, about half the headers carry the key
    task automatic send_random(input string name);
        logic [31:0] r;
        logic [pf_pkg::KEY_W-1:0] key;
        int nw;
        r = $random(seed);
        nw = int'(r % 6) + 1;
        r = $random(seed);
        if (r[0]) begin
            key = MATCH_KEY;
        end else begin
            key = r[pf_pkg::KEY_W:1];
        end
        send_packet(name, nw, key);
    endtask

    // Predicted readiness for the current cycle, checked at its falling edge
    task automatic check_rdy(input string name);
        logic exp;
        bit ok;
        exp = |(~busy);
        step();
        compare_rdy(name, exp, rdy_seen, ok);
        report_test(name, ok);
    endtask

    task automatic drain();
        while (due_q.size() != 0) begin
            step();
        end
    endtask

    initial begin
        int k;
        logic [31:0] r;
        rst_n_i = 1'b0;
        ack_i = 1'b0;
        addr_i = '0;
        wr_data_i = '0;
        byte_inc_i = '0;
        wr_en_i = 1'b0;
        done_i = 1'b0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        step();

        // Isolated packets all land on core 0
        for (k = 0; k < 3; k++) begin
            send_random($sformatf("t1_single_%0d", k));
            drain();
            repeat (3) step();
        end

        // Back to back, no waiting on verdicts
        for (k = 0; k < 4; k++) begin
            send_random($sformatf("t2_b2b_%0d", k));
        end
        drain();

        // A serial source frees each core two cycles after done, so rdy stays high
        check_rdy("t3_rdy_idle");
        send_random("t3_first");
        check_rdy("t3_rdy_one_busy");
        send_random("t3_second");
        drain();
        send_random("t3_after_free");
        drain();

        // Directed accept and drop, short and long
        send_packet("t4_accept_1w", 1, MATCH_KEY);
        send_packet("t4_drop_1w", 1, 16'h86dd);
        send_packet("t4_accept_6w", 6, MATCH_KEY);
        send_packet("t4_drop_6w", 6, 16'h0806);
        drain();

        // Long random run with random idle gaps
        for (k = 0; k < 60; k++) begin
            send_random($sformatf("t5_rand_%0d", k));
            r = $random(seed);
            repeat (int'(r % 6)) step();
        end
        drain();
        repeat (4) step();

        $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/pf_pkg.sv
rtl/snoop_if.sv
rtl/tag_tree.sv
rtl/snoop_arb.sv
rtl/filter_core.sv
rtl/packet_filter_top.sv
testbench/tb_packet_filter.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_packet_filter -Mdir obj_dir -o tb_packet_filter

./obj_dir/tb_packet_filter | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
